/* exec_unit.sv */
module exec_unit
    import npu_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    // instruction queue
    input  logic             i_minst_rd_rdy,
    input  minst_t           i_minst_rd_dout,
    output logic             o_minst_rd_en,
    // input vector buffer
    input  logic             i_vec_rd_rdy,
    input  vec_t             i_vec_rd_dout,
    output logic             o_vec_rd_en,
    // register file
    output logic [VRFAW-1:0] o_rd0_addr,
    output logic [VRFAW-1:0] o_rd1_addr,
    input  vec_t             i_rd0_data,
    input  vec_t             i_rd1_data,
    output logic             o_wr_en,
    output logic [VRFAW-1:0] o_wr_addr,
    output vec_t             o_wr_data,
    // host side
    input  logic             i_start,
    output logic             o_out_valid,
    output vec_t             o_out_data,
    output logic             o_done
);

    minst_t           head;
    logic             use_src0;
    logic             use_src1;
    logic             a_writes;
    logic             hazard;
    logic             load_wait;
    logic             issue;
    logic             a_valid;
    mfu_op_e          a_op;
    logic             a_report;
    logic [VRFAW-1:0] a_dst;
    vec_t             a_opa;
    vec_t             a_opb;
    vec_t             result;

    assign head     = i_minst_rd_dout;
    assign use_src0 = head.op inside {OP_ADD, OP_SUB, OP_MUL, OP_RELU};
    assign use_src1 = head.op inside {OP_ADD, OP_SUB, OP_MUL};
    assign a_writes = a_valid && (a_op != OP_END);

    // stage A result lands in the vrf at the next edge, so only stage A can conflict
    assign hazard    = a_writes && ((use_src0 && a_dst == head.src0) ||
                                    (use_src1 && a_dst == head.src1));
    assign load_wait = (head.op == OP_LOAD) && !i_vec_rd_rdy;
    assign issue     = i_minst_rd_rdy && !hazard && !load_wait;

    assign o_minst_rd_en = issue;
    assign o_vec_rd_en   = issue && (head.op == OP_LOAD);
    assign o_rd0_addr    = head.src0;
    assign o_rd1_addr    = head.src1;

    // stage A
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            a_valid <= 1'b0;
        end else begin
            a_valid <= issue;
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            a_op     <= head.op;
            a_report <= head.report;
            a_dst    <= head.dst;
            a_opa    <= (head.op == OP_LOAD) ? i_vec_rd_dout : i_rd0_data;
            a_opb    <= i_rd1_data;
        end
    end

    // element-wise function unit, wraps at EW bits
    always_comb begin
        for (int i = 0; i < DOTW; i++) begin
            case (a_op)
                OP_ADD:  result[i] = a_opa[i] + a_opb[i];
                OP_SUB:  result[i] = a_opa[i] - a_opb[i];
                OP_MUL:  result[i] = a_opa[i] * a_opb[i];
                OP_RELU: result[i] = a_opa[i][EW-1] ? '0 : a_opa[i];
                default: result[i] = a_opa[i];
            endcase
        end
    end

    // write-back happens on the edge that loads stage B
    assign o_wr_en   = a_writes;
    assign o_wr_addr = a_dst;
    assign o_wr_data = result;

    // stage B
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_out_valid <= a_writes && a_report;
            if (a_valid && a_op == OP_END) begin
                o_done <= 1'b1;
            end else if (i_start) begin
                o_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (a_valid) begin
            o_out_data <= result;
        end
    end

    // results of a program never trail its done flag
    a_no_out_after_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |-> !o_out_valid);

endmodule

/* flist.f */
npu_pkg.sv
npu_fifo.sv
inst_fetch.sv
vrf.sv
exec_unit.sv
npu.sv
npu_tb.sv

/* inst_fetch.sv */
module inst_fetch
    import npu_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_inst_wr_en,
    input  logic [INST_ADDRW-1:0] i_inst_wr_addr,
    input  minst_t                i_inst_wr_din,
    input  logic                  i_start,
    input  logic [INST_ADDRW-1:0] i_pc_start_offset,
    output logic                  o_minst_wr_en,
    input  logic                  i_minst_wr_rdy,
    output minst_t                o_minst_wr_din
);

    minst_t                imem [INST_DEPTH];
    fetch_state_e          state;
    logic [INST_ADDRW-1:0] pc;
    minst_t                rd_data;
    logic                  rd_valid;
    logic                  advance;

    // host side write port
    always_ff @(posedge i_clk) begin
        if (i_inst_wr_en) begin
            imem[i_inst_wr_addr] <= i_inst_wr_din;
        end
    end

    // read register doubles as the hold slot while the queue is full
    assign o_minst_wr_en  = rd_valid && i_minst_wr_rdy;
    assign o_minst_wr_din = rd_data;

    // refill when empty or when the word leaves, never past OP_END
    assign advance = (state == FETCH_RUN) &&
                     (!rd_valid || (o_minst_wr_en && rd_data.op != OP_END));

    always_ff @(posedge i_clk) begin
        if (advance) begin
            rd_data <= imem[pc];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= FETCH_IDLE;
            pc       <= '0;
            rd_valid <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (i_start) begin
                        state <= FETCH_RUN;
                        pc    <= i_pc_start_offset;
                    end
                end
                FETCH_RUN: begin
                    if (advance) begin
                        pc       <= pc + 1'b1;
                        rd_valid <= 1'b1;
                    end else if (o_minst_wr_en) begin
                        // only OP_END leaves without a refill
                        rd_valid <= 1'b0;
                        state    <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // the last word read before the pc wraps has to end the program
    a_pc_no_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        advance && (pc == INST_ADDRW'(INST_DEPTH - 1)) |=> rd_data.op == OP_END);

endmodule

/* npu.sv */
module npu
    import npu_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // instruction memory writes
    input  logic                  i_inst_wr_en,
    input  logic [INST_ADDRW-1:0] i_inst_wr_addr,
    input  minst_t                i_inst_wr_din,
    // input vectors
    input  logic                  i_in_wr_en,
    output logic                  o_in_wr_rdy,
    input  vec_t                  i_in_wr_din,
    // control
    input  logic                  i_start,
    input  logic [INST_ADDRW-1:0] i_pc_start_offset,
    // results
    output logic                  o_out_valid,
    output vec_t                  o_out_data,
    output logic                  o_done
);

    logic             minst_wr_en;
    logic             minst_wr_rdy;
    minst_t           minst_wr_din;
    logic             minst_rd_en;
    logic             minst_rd_rdy;
    minst_t           minst_rd_dout;
    logic             vec_rd_en;
    logic             vec_rd_rdy;
    vec_t             vec_rd_dout;
    logic [VRFAW-1:0] vrf_rd0_addr;
    logic [VRFAW-1:0] vrf_rd1_addr;
    vec_t             vrf_rd0_data;
    vec_t             vrf_rd1_data;
    logic             vrf_wr_en;
    logic [VRFAW-1:0] vrf_wr_addr;
    vec_t             vrf_wr_data;

    inst_fetch u_inst_fetch (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_inst_wr_en      (i_inst_wr_en),
        .i_inst_wr_addr    (i_inst_wr_addr),
        .i_inst_wr_din     (i_inst_wr_din),
        .i_start           (i_start),
        .i_pc_start_offset (i_pc_start_offset),
        .o_minst_wr_en     (minst_wr_en),
        .i_minst_wr_rdy    (minst_wr_rdy),
        .o_minst_wr_din    (minst_wr_din)
    );

    npu_fifo #(
        .DEPTH (QDEPTH),
        .T     (minst_t)
    ) u_inst_queue (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (minst_wr_en),
        .o_wr_rdy  (minst_wr_rdy),
        .i_wr_din  (minst_wr_din),
        .i_rd_en   (minst_rd_en),
        .o_rd_rdy  (minst_rd_rdy),
        .o_rd_dout (minst_rd_dout)
    );

    // loader input buffer
    npu_fifo #(
        .DEPTH (INPUT_BUFFER_SIZE),
        .T     (vec_t)
    ) u_in_buffer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (i_in_wr_en),
        .o_wr_rdy  (o_in_wr_rdy),
        .i_wr_din  (i_in_wr_din),
        .i_rd_en   (vec_rd_en),
        .o_rd_rdy  (vec_rd_rdy),
        .o_rd_dout (vec_rd_dout)
    );

    vrf u_vrf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rd0_addr (vrf_rd0_addr),
        .i_rd1_addr (vrf_rd1_addr),
        .o_rd0_data (vrf_rd0_data),
        .o_rd1_data (vrf_rd1_data),
        .i_wr_en    (vrf_wr_en),
        .i_wr_addr  (vrf_wr_addr),
        .i_wr_data  (vrf_wr_data)
    );

    exec_unit u_exec_unit (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_minst_rd_rdy  (minst_rd_rdy),
        .i_minst_rd_dout (minst_rd_dout),
        .o_minst_rd_en   (minst_rd_en),
        .i_vec_rd_rdy    (vec_rd_rdy),
        .i_vec_rd_dout   (vec_rd_dout),
        .o_vec_rd_en     (vec_rd_en),
        .o_rd0_addr      (vrf_rd0_addr),
        .o_rd1_addr      (vrf_rd1_addr),
        .i_rd0_data      (vrf_rd0_data),
        .i_rd1_data      (vrf_rd1_data),
        .o_wr_en         (vrf_wr_en),
        .o_wr_addr       (vrf_wr_addr),
        .o_wr_data       (vrf_wr_data),
        .i_start         (i_start),
        .o_out_valid     (o_out_valid),
        .o_out_data      (o_out_data),
        .o_done          (o_done)
    );

endmodule

/* npu_fifo.sv */
module npu_fifo
    import npu_pkg::*;
#(
    parameter int  DEPTH = QDEPTH,
    parameter type T     = minst_t
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_wr_en,
    output logic o_wr_rdy,
    input  T     i_wr_din,
    input  logic i_rd_en,
    output logic o_rd_rdy,
    output T     o_rd_dout
);

    T                           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_wr;
    logic                       do_rd;

    assign o_wr_rdy  = (count != DEPTH);
    assign o_rd_rdy  = (count != 0);
    assign do_wr     = i_wr_en && o_wr_rdy;
    assign do_rd     = i_rd_en && o_rd_rdy;
    // head shows while not empty
    assign o_rd_dout = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_din;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer and consumer must respect the ready flags
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr_en |-> o_wr_rdy);
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rd_en |-> o_rd_rdy);

endmodule

/* npu_pkg.sv */
package npu_pkg;

    // datapath sizes
    localparam int EW   = 16;
    localparam int DOTW = 4;

    // vector register file
    localparam int VRFD  = 16;
    localparam int VRFAW = 4;

    // instruction memory
    localparam int INST_DEPTH = 32;
    localparam int INST_ADDRW = 5;

    // queues between fetch, loader and execution
    localparam int QDEPTH            = 4;
    localparam int INPUT_BUFFER_SIZE = 8;

    typedef logic signed [EW-1:0] elem_t;

    // element 0 in the low bits
    typedef elem_t [DOTW-1:0] vec_t;

    // all arithmetic wraps modulo 2^EW
    typedef enum logic [2:0] {
        OP_END  = 3'd0,
        OP_LOAD = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4,
        OP_RELU = 3'd5
    } mfu_op_e;

    // one macro instruction, 16 bits
    typedef struct packed {
        mfu_op_e          op;
        logic             report;
        logic [VRFAW-1:0] dst;
        logic [VRFAW-1:0] src0;
        logic [VRFAW-1:0] src1;
    } minst_t;

    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_RUN  = 1'b1
    } fetch_state_e;

endpackage

/* npu_tb.sv */
module npu_tb
    import npu_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 200;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_inst_wr_en;
    logic [INST_ADDRW-1:0] i_inst_wr_addr;
    minst_t                i_inst_wr_din;
    logic                  i_in_wr_en;
    logic                  o_in_wr_rdy;
    vec_t                  i_in_wr_din;
    logic                  i_start;
    logic [INST_ADDRW-1:0] i_pc_start_offset;
    logic                  o_out_valid;
    vec_t                  o_out_data;
    logic                  o_done;

    // reference model state
    vec_t   model_rf [VRFD];
    vec_t   exp_mem [64];
    int     exp_wr;
    int     exp_rd;
    vec_t   vec_list [$];
    int     load_idx;
    int     push_idx;
    int     prog_pc;
    integer seed;
    string  test_name;
    int     errors;
    int     test_errs;
    int     tests_run;
    int     tests_failed;
    logic   armed;

    npu u_npu (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_inst_wr_en      (i_inst_wr_en),
        .i_inst_wr_addr    (i_inst_wr_addr),
        .i_inst_wr_din     (i_inst_wr_din),
        .i_in_wr_en        (i_in_wr_en),
        .o_in_wr_rdy       (o_in_wr_rdy),
        .i_in_wr_din       (i_in_wr_din),
        .i_start           (i_start),
        .i_pc_start_offset (i_pc_start_offset),
        .o_out_valid       (o_out_valid),
        .o_out_data        (o_out_data),
        .o_done            (o_done)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // expected results leave the model queue one edge after they show
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            exp_rd <= 0;
        end else if (o_out_valid) begin
            exp_rd <= exp_rd + 1;
        end
    end

    // outputs checked mid-cycle, away from the edge that moves them
    a_out_data: assert property (@(negedge i_clk) disable iff (!i_rst_n)
        o_out_valid && (exp_rd != exp_wr) |-> o_out_data == exp_mem[exp_rd])
        else begin
            $display("Fail %s: expected %h, actual %h", test_name, exp_mem[exp_rd], o_out_data);
            errors++;
        end
    a_no_extra_out: assert property (@(negedge i_clk) disable iff (!i_rst_n)
        o_out_valid |-> exp_rd != exp_wr)
        else begin
            $display("%s: a result came out that the program never reported", test_name);
            errors++;
        end
    a_done_complete: assert property (@(negedge i_clk) disable iff (!i_rst_n)
        armed && o_done |-> exp_rd == exp_wr)
        else begin
            $display("%s: done went high while results were still missing", test_name);
            errors++;
        end

    // element-wise rules, wrapping at 16 bits
    function automatic vec_t model_op(input mfu_op_e op, input vec_t a, input vec_t b);
        vec_t r;
        int   p;
        for (int i = 0; i < DOTW; i++) begin
            case (op)
                OP_ADD:  p = int'(a[i]) + int'(b[i]);
                OP_SUB:  p = int'(a[i]) - int'(b[i]);
                OP_MUL:  p = int'(a[i]) * int'(b[i]);
                OP_RELU: p = (a[i] < 0) ? 0 : int'(a[i]);
                default: p = int'(a[i]);
            endcase
            r[i] = p[EW-1:0];
        end
        return r;
    endfunction

    task automatic begin_test(input string name, input int offset);
        test_name = name;
        test_errs = errors;
        prog_pc   = offset;
        load_idx  = 0;
        push_idx  = 0;
        vec_list.delete();
    endtask

    task automatic make_vecs(input int n);
        vec_t   v;
        integer r;
        repeat (n) begin
            for (int i = 0; i < DOTW; i++) begin
                r    = $random(seed);
                v[i] = r[EW-1:0];
            end
            vec_list.push_back(v);
        end
    endtask

    // writes one instruction and steps the model
    task automatic emit(input mfu_op_e op, input logic rep, input logic [VRFAW-1:0] dst,
                        input logic [VRFAW-1:0] s0, input logic [VRFAW-1:0] s1);
        minst_t w;
        vec_t   r;
        w.op           = op;
        w.report       = rep;
        w.dst          = dst;
        w.src0         = s0;
        w.src1         = s1;
        i_inst_wr_en   = 1'b1;
        i_inst_wr_addr = INST_ADDRW'(prog_pc);
        i_inst_wr_din  = w;
        @(posedge i_clk);
        #2;
        i_inst_wr_en = 1'b0;
        prog_pc++;
        if (op == OP_LOAD) begin
            r = vec_list[load_idx];
            load_idx++;
        end else begin
            r = model_op(op, model_rf[s0], model_rf[s1]);
        end
        if (op != OP_END) begin
            model_rf[dst] = r;
            if (rep) begin
                exp_mem[exp_wr] = r;
                exp_wr++;
            end
        end
    endtask

    task automatic push_vecs(input int n);
        repeat (n) begin
            assert (o_in_wr_rdy) else begin
                $display("%s: input buffer not ready for a push", test_name);
                errors++;
            end
            i_in_wr_en  = 1'b1;
            i_in_wr_din = vec_list[push_idx];
            push_idx++;
            @(posedge i_clk);
            #2;
            i_in_wr_en = 1'b0;
        end
    endtask

    task automatic start_prog(input int offset);
        i_start           = 1'b1;
        i_pc_start_offset = INST_ADDRW'(offset);
        @(posedge i_clk);
        #2;
        i_start = 1'b0;
        armed   = 1'b1;
        assert (!o_done) else begin
            $display("%s: done stayed high after start", test_name);
            errors++;
        end
    endtask

    task automatic wait_done();
        do begin
            @(negedge i_clk);
        end while (!o_done);
        @(posedge i_clk);
        #2;
        armed = 1'b0;
        tests_run++;
        if (errors != test_errs) begin
            tests_failed++;
        end
        $display("test %-12s finished, %0d errors", test_name, errors - test_errs);
    endtask

    initial begin
        #((NUM_TESTS * TEST_CYCLES + 5) * CLK_PERIOD);
        $display("watchdog timeout, a test never reached done");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed              = 32'h961e_3144;
        i_rst_n           = 1'b0;
        i_inst_wr_en      = 1'b0;
        i_inst_wr_addr    = '0;
        i_inst_wr_din     = '0;
        i_in_wr_en        = 1'b0;
        i_in_wr_din       = '0;
        i_start           = 1'b0;
        i_pc_start_offset = '0;
        exp_wr            = 0;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        armed             = 1'b0;
        for (int i = 0; i < VRFD; i++) begin
            model_rf[i] = '0;
        end
        repeat (5) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #2;

        begin_test("load_report", 0);
        make_vecs(4);
        for (int i = 0; i < 4; i++) begin
            emit(OP_LOAD, 1'b1, VRFAW'(i), '0, '0);
        end
        emit(OP_END, 1'b0, '0, '0, '0);
        push_vecs(4);
        start_prog(0);
        wait_done();

        begin_test("arith", 8);
        make_vecs(2);
        emit(OP_LOAD, 1'b0, 4'd4, '0, '0);
        emit(OP_LOAD, 1'b0, 4'd5, '0, '0);
        emit(OP_ADD, 1'b1, 4'd6, 4'd4, 4'd5);
        emit(OP_SUB, 1'b1, 4'd7, 4'd4, 4'd5);
        emit(OP_MUL, 1'b1, 4'd8, 4'd4, 4'd5);
        emit(OP_END, 1'b0, '0, '0, '0);
        push_vecs(2);
        start_prog(8);
        wait_done();

        begin_test("relu", 16);
        make_vecs(2);
        emit(OP_LOAD, 1'b0, 4'd9, '0, '0);
        emit(OP_RELU, 1'b1, 4'd10, 4'd9, '0);
        emit(OP_LOAD, 1'b1, 4'd11, '0, '0);
        emit(OP_RELU, 1'b1, 4'd11, 4'd11, '0);
        emit(OP_END, 1'b0, '0, '0, '0);
        push_vecs(2);
        start_prog(16);
        wait_done();

        // every step reads the destination just written
        begin_test("dep_chain", 0);
        make_vecs(1);
        emit(OP_LOAD, 1'b0, 4'd1, '0, '0);
        emit(OP_ADD, 1'b0, 4'd2, 4'd1, 4'd1);
        emit(OP_MUL, 1'b1, 4'd3, 4'd2, 4'd1);
        emit(OP_SUB, 1'b0, 4'd3, 4'd3, 4'd2);
        emit(OP_RELU, 1'b1, 4'd4, 4'd3, '0);
        emit(OP_ADD, 1'b1, 4'd5, 4'd4, 4'd3);
        emit(OP_END, 1'b0, '0, '0, '0);
        push_vecs(1);
        start_prog(0);
        wait_done();

        begin_test("late_load", 20);
        make_vecs(1);
        emit(OP_LOAD, 1'b1, 4'd12, '0, '0);
        emit(OP_ADD, 1'b1, 4'd13, 4'd12, 4'd6);
        emit(OP_END, 1'b0, '0, '0, '0);
        start_prog(20);
        repeat (6) @(posedge i_clk);
        #2;
        push_vecs(1);
        wait_done();

        begin_test("buffer_flags", 23);
        make_vecs(INPUT_BUFFER_SIZE);
        for (int i = 0; i < INPUT_BUFFER_SIZE; i++) begin
            emit(OP_LOAD, 1'b1, VRFAW'(i), '0, '0);
        end
        emit(OP_END, 1'b0, '0, '0, '0);
        push_vecs(INPUT_BUFFER_SIZE);
        assert (!o_in_wr_rdy) else begin
            $display("%s: input buffer still ready after it was filled", test_name);
            errors++;
        end
        start_prog(23);
        wait_done();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* vrf.sv */
module vrf
    import npu_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [VRFAW-1:0] i_rd0_addr,
    input  logic [VRFAW-1:0] i_rd1_addr,
    output vec_t             o_rd0_data,
    output vec_t             o_rd1_data,
    input  logic             i_wr_en,
    input  logic [VRFAW-1:0] i_wr_addr,
    input  vec_t             i_wr_data
);

    vec_t regs [VRFD];

    // combinational read ports
    assign o_rd0_data = regs[i_rd0_addr];
    assign o_rd1_data = regs[i_rd1_addr];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < VRFD; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

endmodule
